// File: cart_mem_top.sv
`timescale 1ns/100ps

module cart_mem_top #(
  parameter logic [16:0] DEAD_TIMEOUT = 17'd84000
) (
  input  logic                              CLK2,
  input  logic                              rst_n,
  input  logic                              snes_cpu_clk_in,
  // mcu side
  input  logic                              mcu_rrq,
  input  logic                              mcu_wrq,
  input  logic [cart_pkg::mcu_addr_w-1:0]   mcu_addr,
  input  logic [cart_pkg::byte_w-1:0]       mcu_dout,
  output logic                              mcu_rdy,
  output logic [cart_pkg::byte_w-1:0]       mcu_din,
  // console state
  output logic                              snes_dead,
  output logic                              snes_reset_strobe,
  // rom psram, 16 bit with byte lanes
  output logic [cart_pkg::mcu_addr_w-2:0]   rom_addr,
  output logic [cart_pkg::rom_word_w-1:0]   rom_wdata,
  input  logic [cart_pkg::rom_word_w-1:0]   rom_rdata,
  output logic                              rom_we,
  output logic                              rom_bhe,
  output logic                              rom_ble,
  // ram sram, 8 bit
  output logic [cart_pkg::ram_addr_w-1:0]   ram_addr,
  output logic [cart_pkg::byte_w-1:0]       ram_wdata,
  input  logic [cart_pkg::byte_w-1:0]       ram_rdata,
  output logic                              ram_we
);
  import cart_pkg::*;

  logic                  slot;
  logic [mcu_addr_w-1:0] ch_addr  [n_chan];
  logic [rom_word_w-1:0] ch_wdata [n_chan];
  logic [rom_word_w-1:0] ch_rdata [n_chan];
  logic [n_chan-1:0]     ch_we;
  logic [n_chan-1:0]     ch_bhe;
  logic [n_chan-1:0]     ch_ble;

  chan_if chan_bus [0:n_chan-1] ();

  // ------------------------------------------------------------------------
  // console clock
  // ------------------------------------------------------------------------
  snes_clk_monitor #(
    .DEAD_TIMEOUT (DEAD_TIMEOUT)
  ) u_clk_mon (
    .CLK2            (CLK2),
    .rst_n           (rst_n),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .slot            (slot),
    .dead            (snes_dead),
    .reset_strobe    (snes_reset_strobe)
  );

  // ------------------------------------------------------------------------
  // mcu request and response
  // ------------------------------------------------------------------------
  mcu_req_router u_router (
    .CLK2     (CLK2),
    .rst_n    (rst_n),
    .mcu_rrq  (mcu_rrq),
    .mcu_wrq  (mcu_wrq),
    .mcu_addr (mcu_addr),
    .mcu_dout (mcu_dout),
    .ch       (chan_bus)
  );

  mcu_resp_collect u_collect (
    .CLK2    (CLK2),
    .rst_n   (rst_n),
    .ch      (chan_bus),
    .mcu_rdy (mcu_rdy),
    .mcu_din (mcu_din)
  );

  // ------------------------------------------------------------------------
  // memory channels
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < n_chan; i++) begin : g_chan
    mem_channel #(
      .CYCLE_LEN (chan_cycle_len[i]),
      .WIDE      (chan_wide[i])
    ) u_chan (
      .CLK2      (CLK2),
      .rst_n     (rst_n),
      .slot      (slot),
      .dead      (snes_dead),
      .abort     (snes_reset_strobe),  // restart when console wakes
      .bus       (chan_bus[i]),
      .mem_addr  (ch_addr[i]),
      .mem_wdata (ch_wdata[i]),
      .mem_rdata (ch_rdata[i]),
      .mem_we    (ch_we[i]),
      .mem_bhe   (ch_bhe[i]),
      .mem_ble   (ch_ble[i])
    );
  end

  // rom pins, word address
  assign rom_addr           = ch_addr[chan_rom][mcu_addr_w-1:1];
  assign rom_wdata          = ch_wdata[chan_rom];
  assign ch_rdata[chan_rom] = rom_rdata;
  assign rom_we             = ch_we[chan_rom];
  assign rom_bhe            = ch_bhe[chan_rom];
  assign rom_ble            = ch_ble[chan_rom];

  // ram pins, low lane only
  assign ram_addr           = ch_addr[chan_ram][ram_addr_w-1:0];
  assign ram_wdata          = ch_wdata[chan_ram][byte_w-1:0];
  assign ch_rdata[chan_ram] = {{(rom_word_w-byte_w){1'b0}}, ram_rdata};
  assign ram_we             = ch_we[chan_ram];

endmodule

// File: cart_pkg.sv
package cart_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------
  localparam int mcu_addr_w = 24;
  localparam int byte_w     = 8;
  localparam int rom_word_w = 16;  // psram data word
  localparam int ram_addr_w = 19;  // 512 KB sram

  // ------------------------------------------------------------------------
  // channels
  // ------------------------------------------------------------------------
  localparam int n_chan   = 2;
  localparam int chan_rom = 0;
  localparam int chan_ram = 1;

  // 880000-8FFFFF goes to the sram
  localparam logic [mcu_addr_w-ram_addr_w-1:0] ram_region = 5'b10001;

  // index 0 is rom, index 1 is ram
  localparam logic [n_chan-1:0][3:0] chan_cycle_len = {4'd5, 4'd7};
  localparam logic [n_chan-1:0]      chan_wide      = 2'b01;  // rom has byte lanes

  // region / offset split of an mcu address
  typedef struct packed {
    logic [mcu_addr_w-ram_addr_w-1:0] region;
    logic [ram_addr_w-1:0]            offset;
  } mcu_addr_split_t;

  // one address word, read flat or as region plus offset
  typedef union packed {
    logic [mcu_addr_w-1:0] flat;
    mcu_addr_split_t       split;
  } mcu_addr_u;

endpackage

// File: chan_if.sv
`timescale 1ns/100ps

interface chan_if;
  import cart_pkg::*;

  // request side, pulses only
  logic              rd_req;
  logic              wr_req;
  mcu_addr_u         addr;
  logic [byte_w-1:0] wdata;

  // response side
  logic              rdy;    // level, low while a request is pending
  logic              done;   // one cycle at end of access
  logic [byte_w-1:0] rdata;  // stable from done until next request

  modport router (
    output rd_req,
    output wr_req,
    output addr,
    output wdata
  );

  modport chan (
    input  rd_req,
    input  wr_req,
    input  addr,
    input  wdata,
    output rdy,
    output done,
    output rdata
  );

  modport collect (
    input rdy,
    input done,
    input rdata
  );

endinterface

// File: compile.f
cart_pkg.sv
chan_if.sv
snes_clk_monitor.sv
mcu_req_router.sv
mem_channel.sv
mcu_resp_collect.sv
cart_mem_top.sv
tb_mem_models.sv
tb_cart_mem.sv

// File: mcu_req_router.sv
`timescale 1ns/100ps

module mcu_req_router (
  input  logic                          CLK2,
  input  logic                          rst_n,
  input  logic                          mcu_rrq,
  input  logic                          mcu_wrq,
  input  logic [cart_pkg::mcu_addr_w-1:0] mcu_addr,
  input  logic [cart_pkg::byte_w-1:0]     mcu_dout,
  chan_if.router                        ch [0:cart_pkg::n_chan-1]
);
  import cart_pkg::*;

  mcu_addr_u         addr_u;
  logic [n_chan-1:0] sel;

  assign addr_u.flat = mcu_addr;

  // region decode, everything outside the sram window is rom
  assign sel[chan_ram] = (addr_u.split.region == ram_region);
  assign sel[chan_rom] = ~sel[chan_ram];

  // ------------------------------------------------------------------------
  // steer pulses, address and data go to all channels
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < n_chan; i++) begin : g_route
    assign ch[i].rd_req = mcu_rrq & sel[i];
    assign ch[i].wr_req = mcu_wrq & sel[i];
    assign ch[i].addr   = addr_u;
    assign ch[i].wdata  = mcu_dout;
  end

  // mcu never asks for read and write at once
  a_rq_excl : assert property (
    @(posedge CLK2) disable iff (!rst_n) !(mcu_rrq && mcu_wrq)
  );

endmodule

// File: mcu_resp_collect.sv
`timescale 1ns/100ps

module mcu_resp_collect (
  input  logic                        CLK2,
  input  logic                        rst_n,
  chan_if.collect                     ch [0:cart_pkg::n_chan-1],
  output logic                        mcu_rdy,
  output logic [cart_pkg::byte_w-1:0] mcu_din
);
  import cart_pkg::*;

  logic [n_chan-1:0] rdy_v;
  logic [n_chan-1:0] done_v;
  logic [byte_w-1:0] rdata_v [n_chan];

  for (genvar i = 0; i < n_chan; i++) begin : g_gather
    assign rdy_v[i]   = ch[i].rdy;
    assign done_v[i]  = ch[i].done;
    assign rdata_v[i] = ch[i].rdata;
  end

  assign mcu_rdy = &rdy_v;  // ready only when nothing is pending anywhere

  // capture on the done edge so data is there when mcu_rdy rises
  always_ff @(posedge CLK2) begin
    for (int i = 0; i < n_chan; i++) begin
      if (done_v[i]) begin
        mcu_din <= rdata_v[i];
      end
    end
  end

  // only one request is ever outstanding
  a_done_onehot : assert property (
    @(posedge CLK2) disable iff (!rst_n) $onehot0(done_v)
  );

endmodule

// File: mem_channel.sv
`timescale 1ns/100ps

module mem_channel #(
  parameter logic [3:0] CYCLE_LEN = 4'd7,
  parameter bit         WIDE      = 1'b1
) (
  input  logic                            CLK2,
  input  logic                            rst_n,
  input  logic                            slot,
  input  logic                            dead,
  input  logic                            abort,
  chan_if.chan                            bus,
  output logic [cart_pkg::mcu_addr_w-1:0] mem_addr,
  output logic [cart_pkg::rom_word_w-1:0] mem_wdata,
  input  logic [cart_pkg::rom_word_w-1:0] mem_rdata,
  output logic                            mem_we,
  output logic                            mem_bhe,
  output logic                            mem_ble
);
  import cart_pkg::*;

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_addr = 2'd1;
  localparam logic [1:0] st_end  = 2'd2;

  logic [1:0]        state;
  logic [3:0]        delay;
  logic              rd_pend;
  logic              wr_pend;
  logic              rdy_q;
  mcu_addr_u         addr_q;
  logic [byte_w-1:0] wdata_q;
  logic [byte_w-1:0] rdata_q;
  logic              busy;
  logic              odd;
  logic [byte_w-1:0] rd_byte;

  // ------------------------------------------------------------------------
  // pending request
  // ------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy_q   <= 1'b1;
    end else if (bus.rd_req) begin
      rd_pend <= 1'b1;
      rdy_q   <= 1'b0;
    end else if (bus.wr_req) begin
      wr_pend <= 1'b1;
      rdy_q   <= 1'b0;
    end else if (state == st_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy_q   <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (bus.rd_req || bus.wr_req) begin
      addr_q  <= bus.addr;
      wdata_q <= bus.wdata;
    end
  end

  // ------------------------------------------------------------------------
  // access sequencer
  // ------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state <= st_idle;
      delay <= '0;
    end else if (abort) begin
      state <= st_idle;  // pending flag stays, access runs again
    end else begin
      case (state)
        st_idle: begin
          // free slot only, or any time with no console
          if ((slot || dead) && (rd_pend || wr_pend)) begin
            state <= st_addr;
            delay <= CYCLE_LEN;
          end
        end
        st_addr: begin
          delay <= delay - 1'b1;
          if (delay == 4'd0) begin
            state <= st_end;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // last sample before st_end wins
  always_ff @(posedge CLK2) begin
    if (state == st_addr && rd_pend) begin
      rdata_q <= rd_byte;
    end
  end

  // ------------------------------------------------------------------------
  // memory pins
  // ------------------------------------------------------------------------
  assign busy = (state != st_idle);
  assign odd  = addr_q.flat[0];  // odd byte is the low lane

  assign rd_byte = (WIDE && !odd) ? mem_rdata[rom_word_w-1:byte_w]
                                  : mem_rdata[byte_w-1:0];

  // rom takes the flat address, ram only the offset
  assign mem_addr = WIDE ? addr_q.flat
                         : {{(mcu_addr_w-ram_addr_w){1'b0}}, addr_q.split.offset};

  assign mem_wdata = (WIDE && !odd) ? {wdata_q, {byte_w{1'b0}}}
                                    : {{byte_w{1'b0}}, wdata_q};

  assign mem_we  = !(state == st_addr && wr_pend);
  assign mem_bhe = !(WIDE && busy && !odd);
  assign mem_ble = !(WIDE && busy && odd);

  assign bus.rdy   = rdy_q;
  assign bus.done  = (state == st_end);
  assign bus.rdata = rdata_q;

  // router must not fire while this channel is still busy
  a_req_when_rdy : assert property (
    @(posedge CLK2) disable iff (!rst_n) (bus.rd_req || bus.wr_req) |-> bus.rdy
  );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e

verilator --binary --timing -f compile.f --top-module tb_cart_mem -o sim_cart_mem

# the simulator exits non-zero on failure, the log search decides
./obj_dir/sim_cart_mem > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
exit 0

// File: snes_clk_monitor.sv
`timescale 1ns/100ps

module snes_clk_monitor #(
  parameter logic [16:0] DEAD_TIMEOUT = 17'd84000  // about 1 ms
) (
  input  logic CLK2,
  input  logic rst_n,
  input  logic snes_cpu_clk_in,
  output logic slot,
  output logic dead,
  output logic reset_strobe
);

  logic [7:0]  cpu_clk_sr;  // bit 0 is the sync stage
  logic [17:0] dead_cnt;
  logic        clk_hi;

  assign clk_hi = cpu_clk_sr[1];

  // ------------------------------------------------------------------------
  // input filter and cycle end detect
  // ------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      cpu_clk_sr <= '0;
      slot       <= 1'b0;
    end else begin
      cpu_clk_sr <= {cpu_clk_sr[6:0], snes_cpu_clk_in};
      // two samples high, then five low
      slot       <= (cpu_clk_sr[7:1] == 7'b1100000);
    end
  end

  // ------------------------------------------------------------------------
  // dead console detect
  // ------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead_cnt <= '0;
    end else if (clk_hi) begin
      dead_cnt <= '0;
    end else if (~&dead_cnt) begin
      dead_cnt <= dead_cnt + 1'b1;  // saturates
    end
  end

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead         <= 1'b1;  // assume no console until clock is seen
      reset_strobe <= 1'b0;
    end else begin
      reset_strobe <= 1'b0;
      if (clk_hi) begin
        dead         <= 1'b0;
        reset_strobe <= dead;  // console just came alive
      end else if (dead_cnt > {1'b0, DEAD_TIMEOUT}) begin
        dead <= 1'b1;
      end
    end
  end

  // revival strobe is a single pulse per wakeup
  a_strobe_single : assert property (
    @(posedge CLK2) disable iff (!rst_n) reset_strobe |=> !reset_strobe
  );

endmodule

// File: tb_cart_mem.sv
`timescale 1ns/100ps

module tb_cart_mem;

  localparam int dead_timeout = 200;
  localparam int n_reqs       = 70;
  localparam int wd_cycles    = 16 + n_reqs * 400 + 4 * dead_timeout;
  localparam int lat_rom      = 11;  // edges from the request edge to mcu_rdy
  localparam int lat_ram      = 9;

  logic        CLK2 = 1'b0;
  logic        rst_n, snes_cpu_clk_in, mcu_rrq, mcu_wrq;
  logic [23:0] mcu_addr;
  logic [7:0]  mcu_dout, mcu_din, ram_wdata, ram_rdata;
  logic        mcu_rdy, snes_dead, snes_reset_strobe;
  logic [22:0] rom_addr;
  logic [15:0] rom_wdata, rom_rdata;
  logic        rom_we, rom_bhe, rom_ble, ram_we;
  logic [18:0] ram_addr;

  logic [7:0]  ref_mem [4096];
  bit          cpu_run = 1'b0;
  int          cpu_cnt = 0;
  logic        cpu_prev = 1'b0;
  logic [7:0]  since_fall = 8'hff;

  always #10 CLK2 = ~CLK2;

  cart_mem_top #(.DEAD_TIMEOUT(17'd200)) DUT (.*);
  tb_mem_models mem (.*);

  // ------------------------------------------------------------------------
  // console cpu clock with a 32 cycle period
  // ------------------------------------------------------------------------
  always @(posedge CLK2) begin
    #2;
    if (!cpu_run) begin
      snes_cpu_clk_in = 1'b0;
      cpu_cnt = 0;
    end else if (cpu_cnt == 15) begin
      snes_cpu_clk_in = ~snes_cpu_clk_in;
      cpu_cnt = 0;
    end else begin
      cpu_cnt = cpu_cnt + 1;
    end
  end

  always @(posedge CLK2) begin  // cycles since last falling cpu clock
    cpu_prev <= snes_cpu_clk_in;
    if (cpu_prev && !snes_cpu_clk_in) since_fall <= 8'd0;
    else if (since_fall != 8'hff) since_fall <= since_fall + 8'd1;
  end

  function automatic logic [7:0] fill_byte(input logic [11:0] key);
    return key[7:0] ^ {key[11:8], key[11:8]} ^ 8'h5a;
  endfunction

  function automatic logic [11:0] key_of(input logic [23:0] a);
    return {a[23:19] == 5'b10001, a[10:0]};
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, sig, got, exp);
    $display(">>> FAIL");
    $fatal(1, "mismatch");
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display(">>> FAIL");
    $fatal(1, "error");
  endtask

  // ------------------------------------------------------------------------
  // memory writes only near a cycle end while the console runs
  // ------------------------------------------------------------------------
  a_rom_slot : assert property (@(posedge CLK2) disable iff (!rst_n || snes_dead)
    $fell(rom_we) |-> since_fall <= 8'd15)
    else report_error("rom write started outside a free slot");

  a_ram_slot : assert property (@(posedge CLK2) disable iff (!rst_n || snes_dead)
    $fell(ram_we) |-> since_fall <= 8'd13)
    else report_error("ram write started outside a free slot");

  // single request that waits for mcu_rdy
  // exp_lat of 0 skips the latency check
  task automatic mcu_access(input bit wr, input logic [23:0] a, input logic [7:0] d,
                            input int exp_lat, output logic [7:0] q);
    int edges;
    bit is_rom;
    bit lane_seen;
    edges     = 1;  // the request edge is the first one
    lane_seen = 1'b0;
    is_rom    = (a[23:19] != 5'b10001);
    @(posedge CLK2);
    #2;
    mcu_rrq  = !wr;
    mcu_wrq  = wr;
    mcu_addr = a;
    mcu_dout = d;
    @(posedge CLK2);  // request edge
    #2;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    do begin
      @(posedge CLK2);
      #1;
      edges++;
      if (is_rom) begin
        if (a[0]) begin
          assert (rom_bhe) else report_mismatch("rom_bhe", rom_bhe, 1);
          if (!rom_ble) lane_seen = 1'b1;
        end else begin
          assert (rom_ble) else report_mismatch("rom_ble", rom_ble, 1);
          if (!rom_bhe) lane_seen = 1'b1;
        end
      end
      if (edges > 1000) report_error("mcu_rdy never returned");
    end while (!mcu_rdy);
    assert (!is_rom || lane_seen) else report_error("rom lane enable never went low");
    if (exp_lat > 0) begin
      assert (edges == exp_lat) else report_mismatch("latency", edges, exp_lat);
    end
    q = mcu_din;
  endtask

  task automatic write_byte(input logic [23:0] a, input logic [7:0] d, input int lat);
    logic [7:0] q;
    mcu_access(1'b1, a, d, lat, q);
    ref_mem[key_of(a)] = d;
  endtask

  task automatic check_read(input logic [23:0] a, input int lat);
    logic [7:0] q;
    mcu_access(1'b0, a, 8'h00, lat, q);
    assert (q == ref_mem[key_of(a)]) else report_mismatch("mcu_din", q, ref_mem[key_of(a)]);
  endtask

  initial begin : watchdog
    repeat (wd_cycles) @(posedge CLK2);
    $display("ERROR: run did not finish in %0d cycles", wd_cycles);
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [23:0] a;
    int          strobes;
    void'($urandom(53647));
    for (int i = 0; i < 4096; i++) ref_mem[i] = fill_byte(i[11:0]);
    rst_n = 1'b0;
    snes_cpu_clk_in = 1'b0;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_addr = '0;
    mcu_dout = '0;
    repeat (16) @(posedge CLK2);
    #2 rst_n = 1'b1;
    @(posedge CLK2);
    #1;
    assert (mcu_rdy) else report_mismatch("mcu_rdy", mcu_rdy, 1);
    assert (rom_we) else report_mismatch("rom_we", rom_we, 1);
    assert (ram_we) else report_mismatch("ram_we", ram_we, 1);
    assert (snes_dead) else report_mismatch("snes_dead", snes_dead, 1);

    // fixed latency with the console dead
    for (int i = 0; i < 6; i++) begin
      r = $urandom();
      a = {5'b10001, 8'd0, r[10:0]};
      write_byte(a, r[23:16], lat_ram);
      check_read(a, lat_ram);
      r = $urandom();
      a = {13'd0, r[10:0]};
      write_byte(a, r[23:16], lat_rom);
      check_read(a, lat_rom);
      check_read({13'd0, r[26:16]}, lat_rom);
    end

    // rom byte lanes
    r = $urandom();
    a = {13'd0, r[10:1], 1'b0};
    write_byte(a | 24'd1, r[31:24], lat_rom);
    check_read(a, lat_rom);
    check_read(a | 24'd1, lat_rom);
    write_byte(a, ~r[31:24], lat_rom);
    check_read(a, lat_rom);
    check_read(a | 24'd1, lat_rom);

    // console alive
    cpu_run = 1'b1;
    while (snes_dead) begin
      @(posedge CLK2);
      #1;
    end
    for (int i = 0; i < 8; i++) begin
      r = $urandom();
      a = {5'b10001, 8'd0, r[10:0]};
      write_byte(a, r[23:16], 0);
      check_read(a, 0);
      a = {13'd0, r[26:16]};
      write_byte(a, r[31:24], 0);
      check_read(a, 0);
    end

    // clock stops and then revives
    cpu_run = 1'b0;
    repeat (2 * dead_timeout) begin
      @(posedge CLK2);
      #1;
      if (snes_dead) break;
    end
    assert (snes_dead) else report_mismatch("snes_dead", snes_dead, 1);
    cpu_run = 1'b1;
    strobes = 0;
    repeat (40) begin
      @(posedge CLK2);
      #1;
      if (snes_reset_strobe) strobes++;
    end
    assert (!snes_dead) else report_mismatch("snes_dead", snes_dead, 0);
    assert (strobes == 1) else report_mismatch("snes_reset_strobe cycles", strobes, 1);

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: tb_mem_models.sv
`timescale 1ns/100ps

module tb_mem_models (
  input  logic        CLK2,
  input  logic [22:0] rom_addr,
  input  logic [15:0] rom_wdata,
  output logic [15:0] rom_rdata,
  input  logic        rom_we,
  input  logic        rom_bhe,
  input  logic        rom_ble,
  input  logic [18:0] ram_addr,
  input  logic [7:0]  ram_wdata,
  output logic [7:0]  ram_rdata,
  input  logic        ram_we
);

  logic [15:0] rom_mem [1024];  // even byte sits in the high lane
  logic [7:0]  ram_mem [2048];

  // key is {is_ram, byte address [10:0]}
  function automatic logic [7:0] fill_byte(input logic [11:0] key);
    return key[7:0] ^ {key[11:8], key[11:8]} ^ 8'h5a;
  endfunction

  initial begin
    for (int i = 0; i < 1024; i++) begin
      rom_mem[i] = {fill_byte({1'b0, i[9:0], 1'b0}), fill_byte({1'b0, i[9:0], 1'b1})};
    end
    for (int i = 0; i < 2048; i++) begin
      ram_mem[i] = fill_byte({1'b1, i[10:0]});
    end
  end

  // write on every clock edge while we is low
  always @(posedge CLK2) begin
    if (!rom_we) begin
      if (!rom_bhe) rom_mem[rom_addr[9:0]][15:8] <= rom_wdata[15:8];
      if (!rom_ble) rom_mem[rom_addr[9:0]][7:0] <= rom_wdata[7:0];
    end
    if (!ram_we) begin
      ram_mem[ram_addr[10:0]] <= ram_wdata;
    end
  end

  assign rom_rdata = rom_mem[rom_addr[9:0]];
  assign ram_rdata = ram_mem[ram_addr[10:0]];

endmodule
